// File: sim.f
design/rename_pkg.sv
design/rename_if.sv
design/rename_dispatch.sv
design/alias_tables.sv
design/free_list.sv
design/reorder_buffer.sv
design/rename_top.sv
bench/rename_checker.sv
bench/rename_monitor.sv
bench/rename_tb.sv

// File: Makefile
SRCS := $(shell cat sim.f)

.PHONY: all run clean

all: run

obj_dir/Vrename_tb: sim.f $(SRCS)
	verilator --binary --timing --assert --top-module rename_tb -Mdir obj_dir -f sim.f

run: obj_dir/Vrename_tb
	@out="$$(./obj_dir/Vrename_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Result: PASSED'

clean:
	rm -rf obj_dir

// File: bench/rename_tb.sv
`timescale 1ns/1ps

module rename_tb;
    import rename_pkg::*;

    localparam int ROB_DEPTH = 8;
    localparam int ID_W = $clog2(ROB_DEPTH);
    localparam int N_INSTR = 2000;
    localparam int TIMEOUT_CYCLES = N_INSTR * 20;
    // No completions or flushes at first, so the ROB fills and stalls
    localparam int FILL_CYCLES = 3 * ROB_DEPTH;

    logic            clk;
    logic            rst;
    logic            inst_valid;
    logic [31:0]     inst;
    logic            complete_valid;
    logic [ID_W-1:0] complete_rob_id;
    logic            flush;
    logic            inst_ready;
    phys_tag_t       phys_rs1;
    phys_tag_t       phys_rs2;
    phys_tag_t       phys_rd;
    logic [ID_W-1:0] rob_id;
    logic            commit_valid;
    arch_reg_t       commit_arch_rd;
    phys_tag_t       commit_phys_rd;
    phys_tag_t       commit_old_phys;
    logic            commit_has_rd;

    int errors;
    int checks;
    int accepts;
    int commits;
    int issued;
    int tail_slot;
    // Slots dispatched but not yet completed
    logic [ID_W-1:0] outstanding [$];

    initial clk = 1'b0;
    always #5 clk = ~clk;

    rename_top #(.ROB_DEPTH(ROB_DEPTH)) i_rename_top (
        .clk             (clk),
        .rst             (rst),
        .inst_valid      (inst_valid),
        .inst            (inst),
        .complete_valid  (complete_valid),
        .complete_rob_id (complete_rob_id),
        .flush           (flush),
        .inst_ready      (inst_ready),
        .phys_rs1        (phys_rs1),
        .phys_rs2        (phys_rs2),
        .phys_rd         (phys_rd),
        .rob_id          (rob_id),
        .commit_valid    (commit_valid),
        .commit_arch_rd  (commit_arch_rd),
        .commit_phys_rd  (commit_phys_rd),
        .commit_old_phys (commit_old_phys),
        .commit_has_rd   (commit_has_rd)
    );

    rename_monitor #(.ROB_DEPTH(ROB_DEPTH)) i_rename_monitor (
        .clk             (clk),
        .rst             (rst),
        .inst_valid      (inst_valid),
        .inst            (inst),
        .complete_valid  (complete_valid),
        .complete_rob_id (complete_rob_id),
        .flush           (flush),
        .inst_ready      (inst_ready),
        .phys_rs1        (phys_rs1),
        .phys_rs2        (phys_rs2),
        .phys_rd         (phys_rd),
        .rob_id          (rob_id),
        .commit_valid    (commit_valid),
        .commit_arch_rd  (commit_arch_rd),
        .commit_phys_rd  (commit_phys_rd),
        .commit_old_phys (commit_old_phys),
        .commit_has_rd   (commit_has_rd),
        .errors          (errors),
        .checks          (checks),
        .accepts         (accepts),
        .commits         (commits)
    );

    bind rename_top rename_checker i_rename_checker (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .inst_ready   (inst_ready),
        .commit_valid (commit_valid)
    );

    // Random word with one of the kept opcodes, rd forced to x0 now and then
    function automatic logic [31:0] random_instr();
        logic [31:0] w;
        w = $urandom();
        case ($urandom_range(8, 0))
            0: w[6:0] = OP;
            1: w[6:0] = OP_IMM;
            2: w[6:0] = LOAD;
            3: w[6:0] = STORE;
            4: w[6:0] = BRANCH;
            5: w[6:0] = JAL;
            6: w[6:0] = JALR;
            7: w[6:0] = LUI;
            default: w[6:0] = AUIPC;
        endcase
        if ($urandom_range(7, 0) == 0) begin
            w[11:7] = 5'd0;
        end
        return w;
    endfunction

    initial begin
        int   cycle;
        int   k;
        logic took;
        logic flushed;
        void'($urandom(32'hed0));
        rst             = 1'b1;
        inst_valid      = 1'b0;
        inst            = '0;
        complete_valid  = 1'b0;
        complete_rob_id = '0;
        flush           = 1'b0;
        issued          = 0;
        tail_slot       = 0;
        cycle           = 0;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        while (issued < N_INSTR) begin
            // Inputs and outputs are settled by the falling edge
            @(negedge clk);
            took    = inst_valid && inst_ready;
            flushed = flush;
            @(posedge clk);
            #1;
            if (took) begin
                outstanding.push_back(ID_W'(tail_slot));
                tail_slot = (tail_slot + 1) % ROB_DEPTH;
                issued++;
            end
            if (flushed) begin
                outstanding.delete();
                tail_slot = 0;
            end
            // A stalled instruction stays on the bus unchanged
            if (took || !inst_valid) begin
                inst_valid = (cycle < FILL_CYCLES || $urandom_range(9, 0) < 8)
                             && (issued < N_INSTR);
                inst = random_instr();
            end
            complete_valid = 1'b0;
            if (cycle >= FILL_CYCLES && outstanding.size() > 0 && $urandom_range(1, 0) == 1) begin
                k = $urandom_range(outstanding.size() - 1, 0);
                complete_valid  = 1'b1;
                complete_rob_id = outstanding[k];
                outstanding.delete(k);
            end
            flush = (cycle >= FILL_CYCLES) && ($urandom_range(59, 0) == 0);
            cycle++;
        end
        // Drain what is left in the ROB
        while (outstanding.size() > 0) begin
            @(posedge clk);
            #1;
            flush           = 1'b0;
            complete_valid  = 1'b1;
            complete_rob_id = outstanding.pop_front();
        end
        @(posedge clk);
        #1;
        flush          = 1'b0;
        complete_valid = 1'b0;
        repeat (ROB_DEPTH + 4) @(posedge clk);
        $display("Checks %0d, value errors %0d, assertion failures %0d, accepted %0d, committed %0d",
                 checks, errors, i_rename_top.i_rename_checker.failures, accepts, commits);
        if (errors == 0 && i_rename_top.i_rename_checker.failures == 0 && commits > 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// File: bench/rename_monitor.sv
`timescale 1ns/1ps

module rename_monitor #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         inst_valid,
    input  logic [31:0]                  inst,
    input  logic                         complete_valid,
    input  logic [$clog2(ROB_DEPTH)-1:0] complete_rob_id,
    input  logic                         flush,
    input  logic                         inst_ready,
    input  rename_pkg::phys_tag_t        phys_rs1,
    input  rename_pkg::phys_tag_t        phys_rs2,
    input  rename_pkg::phys_tag_t        phys_rd,
    input  logic [$clog2(ROB_DEPTH)-1:0] rob_id,
    input  logic                         commit_valid,
    input  rename_pkg::arch_reg_t        commit_arch_rd,
    input  rename_pkg::phys_tag_t        commit_phys_rd,
    input  rename_pkg::phys_tag_t        commit_old_phys,
    input  logic                         commit_has_rd,
    output int                           errors,
    output int                           checks,
    output int                           accepts,
    output int                           commits
);
    import rename_pkg::*;

    localparam int N_FREE = PHYS_REGS - ARCH_REGS;

    int spec_map [ARCH_REGS];
    int ret_map  [ARCH_REGS];
    // Free list as a circular queue with a committed head
    int fl_store [PHYS_REGS];
    int fl_head;
    int fl_tail;
    int fl_ret;
    int rob_rd    [ROB_DEPTH];
    int rob_new   [ROB_DEPTH];
    int rob_old   [ROB_DEPTH];
    bit rob_has   [ROB_DEPTH];
    bit rob_valid [ROB_DEPTH];
    bit rob_done  [ROB_DEPTH];
    int rob_head;
    int rob_tail;
    int rob_count;
    bit first_cycle;

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s expected %0d actual %0d at %0t", name, exp, act, $time);
        end
    endtask

    task automatic clear_rob();
        for (int i = 0; i < ROB_DEPTH; i++) begin
            rob_valid[i] = 1'b0;
            rob_done[i]  = 1'b0;
        end
        rob_head  = 0;
        rob_tail  = 0;
        rob_count = 0;
    endtask

    task automatic reset_model();
        for (int i = 0; i < ARCH_REGS; i++) begin
            spec_map[i] = i;
            ret_map[i]  = i;
        end
        for (int i = 0; i < PHYS_REGS; i++) begin
            fl_store[i] = (i < N_FREE) ? i + ARCH_REGS : 0;
        end
        fl_head     = 0;
        fl_tail     = N_FREE;
        fl_ret      = 0;
        first_cycle = 1'b1;
        errors      = 0;
        checks      = 0;
        accepts     = 0;
        commits     = 0;
        clear_rob();
    endtask

    // Which register fields each RV32I format really uses
    function automatic void decode_operands(input logic [31:0] w, output bit use1,
                                            output bit use2, output bit wr);
        use1 = 1'b0;
        use2 = 1'b0;
        wr   = 1'b0;
        case (w[6:0])
            OP: begin
                use1 = 1'b1;
                use2 = 1'b1;
                wr   = 1'b1;
            end
            OP_IMM, LOAD, JALR: begin
                use1 = 1'b1;
                wr   = 1'b1;
            end
            STORE, BRANCH: begin
                use1 = 1'b1;
                use2 = 1'b1;
            end
            JAL, LUI, AUIPC: begin
                wr = 1'b1;
            end
            default: begin
                wr = 1'b0;
            end
        endcase
    endfunction

    always @(negedge clk) begin
        bit use1;
        bit use2;
        bit wr;
        bit has_rd;
        bit exp_ready;
        bit exp_commit;
        int rd;
        int new_tag;
        int old_tag;
        if (rst) begin
            reset_model();
        end else begin
            decode_operands(inst, use1, use2, wr);
            rd         = wr ? int'(inst[11:7]) : 0;
            has_rd     = wr && (rd != 0);
            old_tag    = spec_map[rd];
            new_tag    = has_rd ? fl_store[fl_head] : old_tag;
            exp_ready  = (rob_count != ROB_DEPTH) && (fl_head != fl_tail) && !flush;
            exp_commit = rob_valid[rob_head] && rob_done[rob_head] && !flush;

            if (first_cycle) begin
                compare_value("reset_ready", 32'd1, 32'(inst_ready));
                compare_value("reset_commit", 32'd0, 32'(commit_valid));
                first_cycle = 1'b0;
            end
            compare_value("inst_ready", 32'(exp_ready), 32'(inst_ready));
            if (inst_valid) begin
                if (use1) begin
                    compare_value("phys_rs1", spec_map[int'(inst[19:15])], 32'(phys_rs1));
                end
                if (use2) begin
                    compare_value("phys_rs2", spec_map[int'(inst[24:20])], 32'(phys_rs2));
                end
                compare_value("phys_rd", new_tag, 32'(phys_rd));
                compare_value("rob_id", rob_tail, 32'(rob_id));
            end
            compare_value("commit_valid", 32'(exp_commit), 32'(commit_valid));
            if (exp_commit && commit_valid) begin
                compare_value("commit_arch_rd", rob_rd[rob_head], 32'(commit_arch_rd));
                compare_value("commit_phys_rd", rob_new[rob_head], 32'(commit_phys_rd));
                compare_value("commit_old_phys", rob_old[rob_head], 32'(commit_old_phys));
                compare_value("commit_has_rd", 32'(rob_has[rob_head]), 32'(commit_has_rd));
            end

            // Advance the model by the coming rising edge
            if (flush) begin
                for (int i = 0; i < ARCH_REGS; i++) begin
                    spec_map[i] = ret_map[i];
                end
                fl_head = fl_ret;
                clear_rob();
            end else begin
                if (complete_valid && rob_valid[complete_rob_id]) begin
                    rob_done[complete_rob_id] = 1'b1;
                end
                if (exp_commit) begin
                    if (rob_has[rob_head]) begin
                        ret_map[rob_rd[rob_head]] = rob_new[rob_head];
                        fl_store[fl_tail] = rob_old[rob_head];
                        fl_tail = (fl_tail + 1) % PHYS_REGS;
                        fl_ret  = (fl_ret + 1) % PHYS_REGS;
                    end
                    rob_valid[rob_head] = 1'b0;
                    rob_head  = (rob_head + 1) % ROB_DEPTH;
                    rob_count--;
                    commits++;
                end
                if (inst_valid && exp_ready) begin
                    if (has_rd) begin
                        spec_map[rd] = new_tag;
                        fl_head = (fl_head + 1) % PHYS_REGS;
                    end
                    rob_rd[rob_tail]    = rd;
                    rob_new[rob_tail]   = new_tag;
                    rob_old[rob_tail]   = old_tag;
                    rob_has[rob_tail]   = has_rd;
                    rob_valid[rob_tail] = 1'b1;
                    rob_done[rob_tail]  = 1'b0;
                    rob_tail  = (rob_tail + 1) % ROB_DEPTH;
                    rob_count++;
                    accepts++;
                end
            end
        end
    end

endmodule

// File: bench/rename_checker.sv
`timescale 1ns/1ps

module rename_checker (
    input logic clk,
    input logic rst,
    input logic flush,
    input logic inst_ready,
    input logic commit_valid
);

    int failures = 0;

    // Flush blocks retirement in the same cycle
    no_commit_in_flush: assert property (
        @(posedge clk) disable iff (rst) flush |-> !commit_valid
    ) else begin
        $error("commit_valid high in a flush cycle");
        failures++;
    end

    no_commit_after_reset: assert property (
        @(posedge clk) rst |=> !commit_valid
    ) else begin
        $error("commit_valid high in the cycle after reset");
        failures++;
    end

    no_ready_in_flush: assert property (
        @(posedge clk) disable iff (rst) flush |-> !inst_ready
    ) else begin
        $error("inst_ready high in a flush cycle");
        failures++;
    end

endmodule

// File: design/rename_top.sv
`timescale 1ns/1ps

module rename_top #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         inst_valid,
    input  logic [31:0]                  inst,
    input  logic                         complete_valid,
    input  logic [$clog2(ROB_DEPTH)-1:0] complete_rob_id,
    input  logic                         flush,
    output logic                         inst_ready,
    output rename_pkg::phys_tag_t        phys_rs1,
    output rename_pkg::phys_tag_t        phys_rs2,
    output rename_pkg::phys_tag_t        phys_rd,
    output logic [$clog2(ROB_DEPTH)-1:0] rob_id,
    output logic                         commit_valid,
    output rename_pkg::arch_reg_t        commit_arch_rd,
    output rename_pkg::phys_tag_t        commit_phys_rd,
    output rename_pkg::phys_tag_t        commit_old_phys,
    output logic                         commit_has_rd
);
    import rename_pkg::*;

    arch_reg_t src_rs1;
    arch_reg_t src_rs2;
    arch_reg_t dst_rd;
    phys_tag_t map_rs1;
    phys_tag_t map_rs2;
    phys_tag_t map_rd_old;
    phys_tag_t free_head;
    logic      free_empty;
    logic      rename_we;

    alloc_if #(.ROB_DEPTH(ROB_DEPTH)) alloc_bus ();
    commit_if commit_bus ();

    rename_dispatch #(.ROB_DEPTH(ROB_DEPTH)) i_rename_dispatch (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .flush      (flush),
        .free_empty (free_empty),
        .free_head  (free_head),
        .map_rs1    (map_rs1),
        .map_rs2    (map_rs2),
        .map_rd_old (map_rd_old),
        .inst_ready (inst_ready),
        .src_rs1    (src_rs1),
        .src_rs2    (src_rs2),
        .dst_rd     (dst_rd),
        .rename_we  (rename_we),
        .rob_id     (rob_id),
        .alloc      (alloc_bus.dispatch)
    );

    alias_tables i_alias_tables (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .src_rs1    (src_rs1),
        .src_rs2    (src_rs2),
        .dst_rd     (dst_rd),
        .rename_we  (rename_we),
        .new_phys   (alloc_bus.new_phys),
        .map_rs1    (map_rs1),
        .map_rs2    (map_rs2),
        .map_rd_old (map_rd_old),
        .retire     (commit_bus.retire)
    );

    // Pops only for accepted instructions that write a register
    free_list i_free_list (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .pop        (rename_we),
        .free_head  (free_head),
        .free_empty (free_empty),
        .retire     (commit_bus.retire)
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) i_reorder_buffer (
        .clk             (clk),
        .rst             (rst),
        .flush           (flush),
        .complete_valid  (complete_valid),
        .complete_rob_id (complete_rob_id),
        .alloc           (alloc_bus.rob),
        .commit          (commit_bus.rob)
    );

    assign phys_rs1        = map_rs1;
    assign phys_rs2        = map_rs2;
    assign phys_rd         = alloc_bus.new_phys;
    assign commit_valid    = commit_bus.commit_valid;
    assign commit_arch_rd  = commit_bus.arch_rd;
    assign commit_phys_rd  = commit_bus.new_phys;
    assign commit_old_phys = commit_bus.old_phys;
    assign commit_has_rd   = commit_bus.has_rd;

endmodule

// File: design/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush,
    input  logic                         complete_valid,
    input  logic [$clog2(ROB_DEPTH)-1:0] complete_rob_id,
    alloc_if.rob                         alloc,
    commit_if.rob                        commit
);
    import rename_pkg::*;

    localparam int ID_W = $clog2(ROB_DEPTH);

    // Entry payload
    arch_reg_t ent_arch_rd  [ROB_DEPTH];
    phys_tag_t ent_new_phys [ROB_DEPTH];
    phys_tag_t ent_old_phys [ROB_DEPTH];
    logic      ent_has_rd   [ROB_DEPTH];

    logic [ROB_DEPTH-1:0] ent_valid;
    logic [ROB_DEPTH-1:0] ent_done;
    logic [ID_W-1:0]      head;
    logic [ID_W-1:0]      tail;
    logic [ID_W:0]        count;
    logic                 do_commit;

    function automatic logic [ID_W-1:0] next_slot(input logic [ID_W-1:0] p);
        return (p == ID_W'(ROB_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign alloc.rob_full = (count == (ID_W + 1)'(ROB_DEPTH));
    assign alloc.alloc_id = tail;

    // Head retires once done, never in a flush cycle
    assign do_commit = ent_valid[head] && ent_done[head] && !flush;

    assign commit.commit_valid = do_commit;
    assign commit.arch_rd      = ent_arch_rd[head];
    assign commit.new_phys     = ent_new_phys[head];
    assign commit.old_phys     = ent_old_phys[head];
    assign commit.has_rd       = ent_has_rd[head];

    always_ff @(posedge clk) begin
        if (alloc.alloc_valid) begin
            ent_arch_rd[tail]  <= alloc.arch_rd;
            ent_new_phys[tail] <= alloc.new_phys;
            ent_old_phys[tail] <= alloc.old_phys;
            ent_has_rd[tail]   <= alloc.has_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            ent_valid <= '0;
            ent_done  <= '0;
            head      <= '0;
            tail      <= '0;
            count     <= '0;
        end else begin
            // Completions for empty slots are dropped
            if (complete_valid && ent_valid[complete_rob_id]) begin
                ent_done[complete_rob_id] <= 1'b1;
            end
            if (do_commit) begin
                ent_valid[head] <= 1'b0;
                head            <= next_slot(head);
            end
            if (alloc.alloc_valid) begin
                ent_valid[tail] <= 1'b1;
                ent_done[tail]  <= 1'b0;
                tail            <= next_slot(tail);
            end
            count <= count + (ID_W + 1)'(alloc.alloc_valid) - (ID_W + 1)'(do_commit);
        end
    end

endmodule

// File: design/free_list.sv
`timescale 1ns/1ps

module free_list (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  pop,
    output rename_pkg::phys_tag_t free_head,
    output logic                  free_empty,
    commit_if.retire              retire
);
    import rename_pkg::*;

    localparam int PTR_W = $clog2(PHYS_REGS);
    localparam int N_FREE = PHYS_REGS - ARCH_REGS;

    phys_tag_t        storage [PHYS_REGS];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    // Head position as seen by committed instructions only
    logic [PTR_W-1:0] ret_head;
    logic             push;

    assign push = retire.commit_valid && retire.has_rd;

    // At most N_FREE tags are ever queued, so head == tail means empty
    assign free_empty = (head == tail);
    assign free_head  = storage[head];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < PHYS_REGS; i++) begin
                if (i < N_FREE) begin
                    storage[i] <= phys_tag_t'(i + ARCH_REGS);
                end else begin
                    storage[i] <= '0;
                end
            end
            head     <= '0;
            tail     <= PTR_W'(N_FREE);
            ret_head <= '0;
        end else begin
            if (push) begin
                storage[tail] <= retire.old_phys;
                tail          <= tail + 1'b1;
                ret_head      <= ret_head + 1'b1;
            end
            // Rewind, popped tags are still in storage
            if (flush) begin
                head <= ret_head;
            end else if (pop) begin
                head <= head + 1'b1;
            end
        end
    end

endmodule

// File: design/alias_tables.sv
`timescale 1ns/1ps

module alias_tables (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  rename_pkg::arch_reg_t src_rs1,
    input  rename_pkg::arch_reg_t src_rs2,
    input  rename_pkg::arch_reg_t dst_rd,
    input  logic                  rename_we,
    input  rename_pkg::phys_tag_t new_phys,
    output rename_pkg::phys_tag_t map_rs1,
    output rename_pkg::phys_tag_t map_rs2,
    output rename_pkg::phys_tag_t map_rd_old,
    commit_if.retire              retire
);
    import rename_pkg::*;

    // Speculative map, written at dispatch
    phys_tag_t spec_map [ARCH_REGS];
    // Retired map, written at commit
    phys_tag_t ret_map [ARCH_REGS];

    assign map_rs1    = spec_map[src_rs1];
    assign map_rs2    = spec_map[src_rs2];
    assign map_rd_old = spec_map[dst_rd];

    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity mapping out of reset
            for (int i = 0; i < ARCH_REGS; i++) begin
                spec_map[i] <= phys_tag_t'(i);
                ret_map[i]  <= phys_tag_t'(i);
            end
        end else begin
            if (retire.commit_valid && retire.has_rd) begin
                ret_map[retire.arch_rd] <= retire.new_phys;
            end
            // Commit is held off during flush, so ret_map is stable here
            if (flush) begin
                spec_map <= ret_map;
            end else if (rename_we) begin
                spec_map[dst_rd] <= new_phys;
            end
        end
    end

endmodule

// File: design/rename_dispatch.sv
`timescale 1ns/1ps

module rename_dispatch #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         inst_valid,
    input  rename_pkg::instr_word_u      inst,
    input  logic                         flush,
    input  logic                         free_empty,
    input  rename_pkg::phys_tag_t        free_head,
    input  rename_pkg::phys_tag_t        map_rs1,
    input  rename_pkg::phys_tag_t        map_rs2,
    input  rename_pkg::phys_tag_t        map_rd_old,
    output logic                         inst_ready,
    output rename_pkg::arch_reg_t        src_rs1,
    output rename_pkg::arch_reg_t        src_rs2,
    output rename_pkg::arch_reg_t        dst_rd,
    output logic                         rename_we,
    output logic [$clog2(ROB_DEPTH)-1:0] rob_id,
    alloc_if.dispatch                    alloc
);
    import rename_pkg::*;

    logic      use_rs1;
    logic      use_rs2;
    logic      writes_rd;
    arch_reg_t rd_field;
    logic      has_rd;
    logic      accept;

    // Operand usage per major opcode
    always_comb begin
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        writes_rd = 1'b0;
        case (inst.r.opcode)
            OP: begin
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                writes_rd = 1'b1;
            end
            OP_IMM, LOAD, JALR: begin
                use_rs1   = 1'b1;
                writes_rd = 1'b1;
            end
            STORE, BRANCH: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            JAL, LUI, AUIPC: begin
                writes_rd = 1'b1;
            end
            default: begin
                writes_rd = 1'b0;
            end
        endcase
    end

    // rd sits at the same bits in every format
    assign rd_field = inst.r.rd;

    // x0 is never renamed
    assign has_rd  = writes_rd && (rd_field != '0);
    assign src_rs1 = use_rs1 ? inst.r.rs1 : '0;
    assign src_rs2 = use_rs2 ? inst.r.rs2 : '0;
    assign dst_rd  = writes_rd ? rd_field : '0;

    // Stall on full ROB or empty free list, and during a flush
    assign inst_ready = !alloc.rob_full && !free_empty && !flush;
    assign accept     = inst_valid && inst_ready;
    assign rename_we  = accept && has_rd;
    assign rob_id     = alloc.alloc_id;

    assign alloc.alloc_valid = accept;
    assign alloc.arch_rd     = dst_rd;
    assign alloc.new_phys    = has_rd ? free_head : map_rd_old;
    assign alloc.old_phys    = map_rd_old;
    assign alloc.has_rd      = has_rd;

endmodule

// File: design/rename_if.sv
`timescale 1ns/1ps

// Dispatch side of the ROB
interface alloc_if #(
    parameter int ROB_DEPTH = 8
);
    import rename_pkg::*;

    logic                         alloc_valid;
    arch_reg_t                    arch_rd;
    phys_tag_t                    new_phys;
    phys_tag_t                    old_phys;
    logic                         has_rd;
    logic                         rob_full;
    logic [$clog2(ROB_DEPTH)-1:0] alloc_id;

    modport dispatch (
        output alloc_valid, arch_rd, new_phys, old_phys, has_rd,
        input  rob_full, alloc_id
    );

    modport rob (
        input  alloc_valid, arch_rd, new_phys, old_phys, has_rd,
        output rob_full, alloc_id
    );

endinterface

// Retire side of the ROB, no back-pressure
interface commit_if;
    import rename_pkg::*;

    logic      commit_valid;
    arch_reg_t arch_rd;
    phys_tag_t new_phys;
    phys_tag_t old_phys;
    logic      has_rd;

    modport rob (
        output commit_valid, arch_rd, new_phys, old_phys, has_rd
    );

    modport retire (
        input commit_valid, arch_rd, new_phys, old_phys, has_rd
    );

endinterface

// File: design/rename_pkg.sv
package rename_pkg;

    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;

    typedef logic [$clog2(ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(PHYS_REGS)-1:0] phys_tag_t;

    // RV32I major opcodes handled by the renamer
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_t;

    // R/I/S/B field layout
    typedef struct packed {
        logic [6:0] funct7;
        arch_reg_t  rs2;
        arch_reg_t  rs1;
        logic [2:0] funct3;
        arch_reg_t  rd;
        opcode_t    opcode;
    } reg_view_t;

    // U/J field layout
    typedef struct packed {
        logic [19:0] imm;
        arch_reg_t   rd;
        opcode_t     opcode;
    } upper_view_t;

    typedef union packed {
        reg_view_t   r;
        upper_view_t u;
    } instr_word_u;

endpackage
